//--- common/matmul_pkg.sv
package matmul_pkg;

  // element and matrix geometry
  localparam int DWIDTH    = 8;
  localparam int MAT_SIZE  = 4;
  localparam int AWIDTH    = 6;
  localparam int ACC_WIDTH = 16;
  localparam int WWIDTH    = MAT_SIZE * DWIDTH;
  localparam int IDX_WIDTH = $clog2(MAT_SIZE);
  localparam int MEM_BYTES = 2 ** AWIDTH;

  typedef logic [DWIDTH-1:0]    data_t;
  typedef logic [WWIDTH-1:0]    word_t;
  typedef logic [AWIDTH-1:0]    addr_t;
  typedef logic [MAT_SIZE-1:0]  wmask_t;
  typedef logic [ACC_WIDTH-1:0] acc_t;
  typedef logic [IDX_WIDTH-1:0] idx_t;
  typedef logic [1:0]           mem_sel_t;

  // last row/column index, used by the engine counters
  localparam idx_t LAST_IDX = idx_t'(MAT_SIZE - 1);

  // memory select codes on the host port
  localparam mem_sel_t MEM_A = 2'd0;
  localparam mem_sel_t MEM_B = 2'd1;
  localparam mem_sel_t MEM_C = 2'd2;

  typedef enum logic [1:0] {
    IDLE,
    LAUNCH,
    RUN,
    DONE
  } ctrl_state_t;

  typedef enum logic [1:0] {
    E_IDLE,
    E_READ,
    E_DRAIN,
    E_WRITE
  } eng_state_t;

endpackage

//--- src/word_ram.sv
`timescale 1ns/1ps

module word_ram import matmul_pkg::*; (
  input  logic   clk,
  input  addr_t  addr,
  input  word_t  wdata,
  input  wmask_t we,
  output word_t  rdata
);

  // byte wide storage, words are four consecutive bytes
  data_t mem [MEM_BYTES];

  always_ff @(posedge clk) begin
    for (int i = 0; i < MAT_SIZE; i++) begin
      if (we[i]) begin
        mem[addr + addr_t'(i)] <= wdata[DWIDTH*i +: DWIDTH];
      end
    end
  end

  // registered read, returns the old bytes when the same word is written
  always_ff @(posedge clk) begin
    for (int i = 0; i < MAT_SIZE; i++) begin
      rdata[DWIDTH*i +: DWIDTH] <= mem[addr + addr_t'(i)];
    end
  end

  // a misaligned write would wrap into the neighbouring word
  a_write_aligned: assert property (
    @(posedge clk) (|we) |-> (addr[1:0] == 2'b00)
  ) else $error("word_ram: write to unaligned address %h", addr);

endmodule

//--- src/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import matmul_pkg::*; (
  input  logic     clk,
  input  logic     resetn,

  // host port
  input  logic     host_req,
  input  mem_sel_t host_sel,
  input  addr_t    host_addr,
  input  word_t    host_wdata,
  input  wmask_t   host_we,
  output logic     host_gnt,
  output word_t    host_rdata,

  // engine port
  input  logic     eng_active,
  input  addr_t    eng_addr_a,
  input  addr_t    eng_addr_b,
  input  addr_t    eng_addr_c,
  input  word_t    eng_wdata_c,
  input  wmask_t   eng_we_c,
  output word_t    rdata_a,
  output word_t    rdata_b,

  // memory side
  output addr_t    mem_addr_a,
  output addr_t    mem_addr_b,
  output addr_t    mem_addr_c,
  output word_t    mem_wdata_a,
  output word_t    mem_wdata_b,
  output word_t    mem_wdata_c,
  output wmask_t   mem_we_a,
  output wmask_t   mem_we_b,
  output wmask_t   mem_we_c,
  input  word_t    q_a,
  input  word_t    q_b,
  input  word_t    q_c
);

  mem_sel_t rd_sel_q;

  // engine always wins, the host just waits
  assign host_gnt = host_req && !eng_active;

  assign mem_addr_a = eng_active ? eng_addr_a : host_addr;
  assign mem_addr_b = eng_active ? eng_addr_b : host_addr;
  assign mem_addr_c = eng_active ? eng_addr_c : host_addr;

  // A and B are read only for the engine
  assign mem_wdata_a = host_wdata;
  assign mem_wdata_b = host_wdata;
  assign mem_wdata_c = eng_active ? eng_wdata_c : host_wdata;

  assign mem_we_a = (host_gnt && host_sel == MEM_A) ? host_we : '0;
  assign mem_we_b = (host_gnt && host_sel == MEM_B) ? host_we : '0;
  assign mem_we_c = eng_active ? eng_we_c :
                    ((host_gnt && host_sel == MEM_C) ? host_we : '0);

  assign rdata_a = q_a;
  assign rdata_b = q_b;

  // remember which memory the granted access went to, data follows a cycle later
  always_ff @(posedge clk) begin
    if (!resetn) begin
      rd_sel_q <= MEM_A;
    end else if (host_gnt) begin
      rd_sel_q <= host_sel;
    end
  end

  always_comb begin
    case (rd_sel_q)
      MEM_A:   host_rdata = q_a;
      MEM_B:   host_rdata = q_b;
      MEM_C:   host_rdata = q_c;
      default: host_rdata = '0;
    endcase
  end

  a_no_gnt_in_run: assert property (
    @(posedge clk) disable iff (!resetn) eng_active |-> !host_gnt
  ) else $error("mem_arbiter: host granted during engine run");

  a_eng_ro_ab: assert property (
    @(posedge clk) disable iff (!resetn)
      eng_active |-> (mem_we_a == '0) && (mem_we_b == '0)
  ) else $error("mem_arbiter: write to A or B during engine run");

endmodule

//--- src/matmul_ctrl.sv
`timescale 1ns/1ps

module matmul_ctrl import matmul_pkg::*; (
  input  logic clk,
  input  logic resetn,
  input  logic start,
  input  logic clear_done,
  input  logic done_mat_mul,
  output logic start_mat_mul,
  output logic busy,
  output logic done
);

  ctrl_state_t state;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state         <= IDLE;
      start_mat_mul <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          start_mat_mul <= 1'b0;
          if (start) begin
            state <= LAUNCH;
          end
        end
        LAUNCH: begin
          // engine sees the level from the next cycle on
          start_mat_mul <= 1'b1;
          state         <= RUN;
        end
        RUN: begin
          if (done_mat_mul) begin
            start_mat_mul <= 1'b0;
            state         <= DONE;
          end
        end
        DONE: begin
          // hold done until the host acknowledges it
          if (clear_done) begin
            state <= IDLE;
          end
        end
        default: begin
          start_mat_mul <= 1'b0;
          state         <= IDLE;
        end
      endcase
    end
  end

  assign busy = (state == LAUNCH) || (state == RUN);
  assign done = (state == DONE);

  // the engine must only finish a run that was launched
  a_done_in_run: assert property (
    @(posedge clk) disable iff (!resetn) done_mat_mul |-> (state == RUN)
  ) else $error("matmul_ctrl: done_mat_mul outside RUN");

endmodule

//--- matmul/mac_cell.sv
`timescale 1ns/1ps

module mac_cell import matmul_pkg::*; (
  input  logic  clk,
  input  logic  resetn,
  input  logic  clear,
  input  logic  en,
  input  data_t a,
  input  data_t b,
  output data_t sum
);

  acc_t                 acc;
  acc_t                 prod;
  logic [ACC_WIDTH:0]   acc_next;

  assign prod     = a * b;
  assign acc_next = {1'b0, acc} + {1'b0, prod};

  always_ff @(posedge clk) begin
    if (!resetn) begin
      acc <= '0;
    end else if (clear) begin
      acc <= '0;
    end else if (en) begin
      // clamp on carry, a wrapped sum could fall back under 255
      acc <= acc_next[ACC_WIDTH] ? '1 : acc_next[ACC_WIDTH-1:0];
    end
  end

  // anything past one byte reads as full scale
  assign sum = (acc > acc_t'({DWIDTH{1'b1}})) ? '1 : acc[DWIDTH-1:0];

endmodule

//--- matmul/matmul_engine.sv
`timescale 1ns/1ps

module matmul_engine import matmul_pkg::*; (
  input  logic   clk,
  input  logic   resetn,
  input  logic   start_mat_mul,
  output logic   done_mat_mul,
  output logic   eng_active,
  output addr_t  eng_addr_a,
  output addr_t  eng_addr_b,
  output addr_t  eng_addr_c,
  input  word_t  rdata_a,
  input  word_t  rdata_b,
  output word_t  eng_wdata_c,
  output wmask_t eng_we_c
);

  eng_state_t state;
  idx_t       cnt;
  addr_t      word_addr;
  logic       launch;
  logic       acc_en_q;
  data_t      cell_sum [MAT_SIZE][MAT_SIZE];

  assign launch = (state == E_IDLE) && start_mat_mul;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= E_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        E_IDLE: begin
          cnt <= '0;
          if (start_mat_mul) begin
            state <= E_READ;
          end
        end
        E_READ: begin
          cnt <= cnt + idx_t'(1);
          if (cnt == LAST_IDX) begin
            state <= E_DRAIN;
          end
        end
        E_DRAIN: begin
          // last A column and B row arrive in this cycle
          cnt   <= '0;
          state <= E_WRITE;
        end
        E_WRITE: begin
          cnt <= cnt + idx_t'(1);
          if (cnt == LAST_IDX) begin
            state <= E_IDLE;
          end
        end
        default: begin
          cnt   <= '0;
          state <= E_IDLE;
        end
      endcase
    end
  end

  // memory read latency is one cycle, so accumulate one cycle behind the address
  always_ff @(posedge clk) begin
    if (!resetn) begin
      acc_en_q <= 1'b0;
    end else begin
      acc_en_q <= (state == E_READ);
    end
  end

  // step k reads column k of A and row k of B, write-back reuses it as row index
  assign word_addr  = addr_t'({cnt, 2'b00});
  assign eng_addr_a = word_addr;
  assign eng_addr_b = word_addr;
  assign eng_addr_c = word_addr;

  assign eng_active   = (state != E_IDLE);
  assign done_mat_mul = (state == E_WRITE) && (cnt == LAST_IDX);
  assign eng_we_c     = (state == E_WRITE) ? '1 : '0;

  // outer product array, cell (i,j) holds C[i][j]
  for (genvar i = 0; i < MAT_SIZE; i++) begin : g_row
    for (genvar j = 0; j < MAT_SIZE; j++) begin : g_col
      mac_cell u_cell (
        .clk    (clk),
        .resetn (resetn),
        .clear  (launch),
        .en     (acc_en_q),
        .a      (rdata_a[DWIDTH*i +: DWIDTH]),
        .b      (rdata_b[DWIDTH*j +: DWIDTH]),
        .sum    (cell_sum[i][j])
      );
    end
  end

  // one C row per write cycle
  always_comb begin
    eng_wdata_c = '0;
    for (int j = 0; j < MAT_SIZE; j++) begin
      eng_wdata_c[DWIDTH*j +: DWIDTH] = cell_sum[cnt][j];
    end
  end

  // 4 reads, 1 drain, 4 writes after the launch cycle
  a_fixed_latency: assert property (
    @(posedge clk) disable iff (!resetn) launch |-> ##9 done_mat_mul
  ) else $error("matmul_engine: run length is not 10 cycles");

endmodule

//--- src/matmul_top.sv
`timescale 1ns/1ps

module matmul_top import matmul_pkg::*; (
  input  logic     clk,
  input  logic     resetn,
  input  logic     start,
  input  logic     clear_done,
  output logic     done,
  output logic     busy,
  input  logic     host_req,
  input  mem_sel_t host_sel,
  input  addr_t    host_addr,
  input  word_t    host_wdata,
  input  wmask_t   host_we,
  output logic     host_gnt,
  output word_t    host_rdata
);

  logic   start_mat_mul;
  logic   done_mat_mul;
  logic   eng_active;
  addr_t  eng_addr_a;
  addr_t  eng_addr_b;
  addr_t  eng_addr_c;
  word_t  eng_wdata_c;
  wmask_t eng_we_c;
  word_t  rdata_a;
  word_t  rdata_b;

  addr_t  mem_addr_a;
  addr_t  mem_addr_b;
  addr_t  mem_addr_c;
  word_t  mem_wdata_a;
  word_t  mem_wdata_b;
  word_t  mem_wdata_c;
  wmask_t mem_we_a;
  wmask_t mem_we_b;
  wmask_t mem_we_c;
  word_t  q_a;
  word_t  q_b;
  word_t  q_c;

  matmul_ctrl u_ctrl (
    .clk           (clk),
    .resetn        (resetn),
    .start         (start),
    .clear_done    (clear_done),
    .done_mat_mul  (done_mat_mul),
    .start_mat_mul (start_mat_mul),
    .busy          (busy),
    .done          (done)
  );

  matmul_engine u_engine (
    .clk           (clk),
    .resetn        (resetn),
    .start_mat_mul (start_mat_mul),
    .done_mat_mul  (done_mat_mul),
    .eng_active    (eng_active),
    .eng_addr_a    (eng_addr_a),
    .eng_addr_b    (eng_addr_b),
    .eng_addr_c    (eng_addr_c),
    .rdata_a       (rdata_a),
    .rdata_b       (rdata_b),
    .eng_wdata_c   (eng_wdata_c),
    .eng_we_c      (eng_we_c)
  );

  mem_arbiter u_arbiter (
    .clk         (clk),
    .resetn      (resetn),
    .host_req    (host_req),
    .host_sel    (host_sel),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_we     (host_we),
    .host_gnt    (host_gnt),
    .host_rdata  (host_rdata),
    .eng_active  (eng_active),
    .eng_addr_a  (eng_addr_a),
    .eng_addr_b  (eng_addr_b),
    .eng_addr_c  (eng_addr_c),
    .eng_wdata_c (eng_wdata_c),
    .eng_we_c    (eng_we_c),
    .rdata_a     (rdata_a),
    .rdata_b     (rdata_b),
    .mem_addr_a  (mem_addr_a),
    .mem_addr_b  (mem_addr_b),
    .mem_addr_c  (mem_addr_c),
    .mem_wdata_a (mem_wdata_a),
    .mem_wdata_b (mem_wdata_b),
    .mem_wdata_c (mem_wdata_c),
    .mem_we_a    (mem_we_a),
    .mem_we_b    (mem_we_b),
    .mem_we_c    (mem_we_c),
    .q_a         (q_a),
    .q_b         (q_b),
    .q_c         (q_c)
  );

  // A columns, B rows, C rows
  word_ram ram_a (
    .clk   (clk),
    .addr  (mem_addr_a),
    .wdata (mem_wdata_a),
    .we    (mem_we_a),
    .rdata (q_a)
  );

  word_ram ram_b (
    .clk   (clk),
    .addr  (mem_addr_b),
    .wdata (mem_wdata_b),
    .we    (mem_we_b),
    .rdata (q_b)
  );

  word_ram ram_c (
    .clk   (clk),
    .addr  (mem_addr_c),
    .wdata (mem_wdata_c),
    .we    (mem_we_c),
    .rdata (q_c)
  );

endmodule

//--- verification/tb_matmul_top.sv
`timescale 1ns/1ps

module tb_matmul_top import matmul_pkg::*; ();

  localparam int NUM_RUNS    = 12;
  localparam int NUM_RW      = 40;
  localparam int INIT_WORDS  = 3 * MEM_BYTES / MAT_SIZE;
  localparam int LOAD_CYCLES = 10 + 4 * (INIT_WORDS + 2 * NUM_RW + NUM_RUNS * 12);
  localparam int WATCHDOG_NS = (NUM_RUNS * 40 + LOAD_CYCLES) * 40;

  logic     clk;
  logic     resetn;
  logic     start;
  logic     clear_done;
  logic     done;
  logic     busy;
  logic     host_req;
  mem_sel_t host_sel;
  addr_t    host_addr;
  word_t    host_wdata;
  wmask_t   host_we;
  logic     host_gnt;
  word_t    host_rdata;

  integer seed;
  // byte mirror of memories A, B and C, indexed by the select code
  data_t  model_mem [3][MEM_BYTES];

  matmul_top uut (
    .clk        (clk),
    .resetn     (resetn),
    .start      (start),
    .clear_done (clear_done),
    .done       (done),
    .busy       (busy),
    .host_req   (host_req),
    .host_sel   (host_sel),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_we    (host_we),
    .host_gnt   (host_gnt),
    .host_rdata (host_rdata)
  );

  always #20 clk = ~clk;

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run hung, done or host_gnt never arrived");
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic word_t model_word(input mem_sel_t sel, input addr_t addr);
    word_t w;
    for (int i = 0; i < MAT_SIZE; i++) begin
      w[DWIDTH*i +: DWIDTH] = model_mem[sel][addr + i];
    end
    return w;
  endfunction

  // mode 0 keeps sums small, mode 2 pushes every element near full scale
  function automatic data_t rand_elem(input int mode);
    data_t r;
    r = data_t'($random(seed));
    case (mode)
      0:       return r & 8'h07;
      2:       return r | 8'hf0;
      default: return r;
    endcase
  endfunction

  // C[i][j] = sum over k of A[i][k] * B[k][j], clamped to 255
  function automatic void compute_model_c();
    int acc;
    for (int i = 0; i < MAT_SIZE; i++) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        acc = 0;
        for (int k = 0; k < MAT_SIZE; k++) begin
          acc += int'(model_mem[MEM_A][4*k+i]) * int'(model_mem[MEM_B][4*k+j]);
        end
        model_mem[MEM_C][4*i+j] = (acc > 255) ? 8'hff : data_t'(acc);
      end
    end
  endfunction

  // request held from a falling edge until a rising edge sees the grant
  task automatic host_access(input mem_sel_t sel, input addr_t addr, input word_t wdata,
                             input wmask_t we, output word_t rdata);
    @(negedge clk);
    host_req   = 1'b1;
    host_sel   = sel;
    host_addr  = addr;
    host_wdata = wdata;
    host_we    = we;
    #10;
    while (!host_gnt) begin
      @(negedge clk);
      #10;
    end
    @(negedge clk);
    rdata    = host_rdata;
    host_req = 1'b0;
    host_we  = '0;
  endtask

  task automatic host_write(input mem_sel_t sel, input addr_t addr, input word_t wdata,
                            input wmask_t we);
    word_t rd;
    host_access(sel, addr, wdata, we, rd);
    for (int i = 0; i < MAT_SIZE; i++) begin
      if (we[i]) begin
        model_mem[sel][addr + i] = wdata[DWIDTH*i +: DWIDTH];
      end
    end
  endtask

  task automatic host_read(input mem_sel_t sel, input addr_t addr);
    word_t rd;
    host_access(sel, addr, '0, '0, rd);
    check_word("host_rdata", model_word(sel, addr), rd);
  endtask

  task automatic load_operands(input int mode);
    word_t wa;
    word_t wb;
    for (int k = 0; k < MAT_SIZE; k++) begin
      for (int i = 0; i < MAT_SIZE; i++) begin
        wa[DWIDTH*i +: DWIDTH] = rand_elem(mode);
        wb[DWIDTH*i +: DWIDTH] = rand_elem(mode);
      end
      host_write(MEM_A, addr_t'(4*k), wa, 4'hf);
      host_write(MEM_B, addr_t'(4*k), wb, 4'hf);
    end
    compute_model_c();
  endtask

  task automatic start_run();
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_bit("busy", 1'b1, busy);
  endtask

  task automatic wait_done();
    while (!done) begin
      @(negedge clk);
    end
    check_bit("busy", 1'b0, busy);
  endtask

  task automatic clear_run();
    @(negedge clk);
    clear_done = 1'b1;
    @(negedge clk);
    clear_done = 1'b0;
    check_bit("done", 1'b0, done);
  endtask

  task automatic check_c_all();
    for (int i = 0; i < MAT_SIZE; i++) begin
      host_read(MEM_C, addr_t'(4*i));
    end
  endtask

  // request C row 0 once the engine owns the memories, it must wait for the end of the run
  task automatic blocked_read();
    word_t rd;
    repeat (2) @(negedge clk);
    host_req   = 1'b1;
    host_sel   = MEM_C;
    host_addr  = '0;
    host_wdata = '0;
    host_we    = '0;
    #10;
    check_bit("busy", 1'b1, busy);
    while (busy) begin
      check_bit("host_gnt", 1'b0, host_gnt);
      @(negedge clk);
      #10;
    end
    check_bit("done", 1'b1, done);
    check_bit("host_gnt", 1'b1, host_gnt);
    @(negedge clk);
    rd       = host_rdata;
    host_req = 1'b0;
    check_word("host_rdata", model_word(MEM_C, '0), rd);
  endtask

  initial begin
    mem_sel_t sel;
    addr_t    addr;
    wmask_t   we;
    word_t    wd;
    seed       = 32'hed2a;
    clk        = 1'b0;
    resetn     = 1'b0;
    start      = 1'b0;
    clear_done = 1'b0;
    host_req   = 1'b0;
    host_sel   = MEM_A;
    host_addr  = '0;
    host_wdata = '0;
    host_we    = '0;
    repeat (10) @(negedge clk);
    resetn = 1'b1;

    // idle state after reset, host gets the memories at once
    check_bit("done", 1'b0, done);
    check_bit("busy", 1'b0, busy);
    check_bit("host_gnt", 1'b0, host_gnt);
    @(negedge clk);
    host_req = 1'b1;
    #10;
    check_bit("host_gnt", 1'b1, host_gnt);
    @(negedge clk);
    host_req = 1'b0;

    for (int s = 0; s < 3; s++) begin
      for (int w = 0; w < MEM_BYTES / MAT_SIZE; w++) begin
        host_write(mem_sel_t'(s), addr_t'(4*w), word_t'($random(seed)), 4'hf);
      end
    end

    // byte lanes and read select
    repeat (NUM_RW) begin
      sel  = mem_sel_t'({$random(seed)} % 3);
      addr = addr_t'(({$random(seed)} % 16) * 4);
      we   = wmask_t'($random(seed));
      wd   = word_t'($random(seed));
      host_write(sel, addr, wd, we);
      host_read(sel, addr);
    end

    // saturating run
    load_operands(2);
    start_run();
    wait_done();
    check_c_all();
    clear_run();

    // host stalled during a run
    load_operands(0);
    start_run();
    blocked_read();
    check_c_all();
    clear_run();

    // start is ignored while done is held
    load_operands(1);
    start_run();
    wait_done();
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_bit("done", 1'b1, done);
      check_bit("busy", 1'b0, busy);
    end
    clear_run();
    // small operands after a large run, any leftover sum would show in C
    load_operands(0);
    start_run();
    wait_done();
    check_c_all();
    clear_run();

    repeat (8) begin
      load_operands({$random(seed)} % 3);
      start_run();
      wait_done();
      check_c_all();
      clear_run();
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- tb.f
common/matmul_pkg.sv
src/word_ram.sv
src/mem_arbiter.sv
src/matmul_ctrl.sv
matmul/mac_cell.sv
matmul/matmul_engine.sv
src/matmul_top.sv
verification/tb_matmul_top.sv

//--- Bender.yml
package:
  name: matmul

sources:
  - common/matmul_pkg.sv
  - src/word_ram.sv
  - src/mem_arbiter.sv
  - src/matmul_ctrl.sv
  - matmul/mac_cell.sv
  - matmul/matmul_engine.sv
  - src/matmul_top.sv
  - target: test
    files:
      - verification/tb_matmul_top.sv
